//--- hw/natv_periph_pkg.sv
// native bus peripheral package: bus, pad and register map types
`default_nettype none

package natv_periph_pkg;

  // one request from the cpu side
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } natv_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } natv_rsp_t;

  // oeb, pub and pdb are active low at the pad
  typedef struct packed {
    logic [7:0] out;
    logic [7:0] oeb;
    logic [7:0] pub;
    logic [7:0] pdb;
  } gpio_pad_t;

  // offsets within the low 16 address bits
  typedef enum logic [15:0] {
    REG_GPIO_DATA  = 16'h0000,
    REG_GPIO_OEB   = 16'h0004,
    REG_GPIO_PUB   = 16'h0008,
    REG_GPIO_PDB   = 16'h000C,
    REG_UART_DIV   = 16'h1000,
    REG_UART_DAT   = 16'h1004,
    REG_TIM0_CFG   = 16'h2000,
    REG_TIM0_VAL   = 16'h2004,
    REG_TIM0_DAT   = 16'h2008,
    REG_TIM1_CFG   = 16'h3000,
    REG_TIM1_VAL   = 16'h3004,
    REG_TIM1_DAT   = 16'h3008,
    REG_PSRAM_WAIT = 16'h4000,
    REG_PSRAM_CHD  = 16'h4004,
    REG_SPISD_DIV  = 16'h5000
  } natv_reg_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

//--- hw/natv_uart.sv
// simple 8N1 uart with a shared baud divider and a one-byte receive buffer
`timescale 1ns/1ps
`default_nettype none

module natv_uart #(
  parameter logic [31:0] DIV_RESET = 32'd16
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        rx_i,
  output logic             tx_o,
  input  wire logic [3:0]  div_we_i,
  input  wire logic        dat_we_i,
  input  wire logic        dat_re_i,
  input  wire logic [31:0] wdata_i,
  output logic [31:0]      div_o,
  output logic [31:0]      dat_o,
  output logic             dat_wait_o,
  output logic             irq_o
);

  logic [31:0] div_q;
  natv_periph_pkg::uart_state_e tx_state_q;
  natv_periph_pkg::uart_state_e rx_state_q;
  logic [31:0] tx_cnt_q;
  logic [31:0] rx_cnt_q;
  logic [2:0]  tx_idx_q;
  logic [2:0]  rx_idx_q;
  logic [7:0]  tx_shift_q;
  logic [7:0]  rx_shift_q;
  logic [7:0]  rx_data_q;
  logic        tx_q;
  logic        rx_valid_q;
  logic [1:0]  rx_sync_q;
  logic        rx_s;
  logic        tx_busy;
  logic        tx_tick;
  logic        rx_tick;
  logic        rx_half;

  assign rx_s       = rx_sync_q[1];
  assign tx_busy    = (tx_state_q != natv_periph_pkg::UART_IDLE);
  // >= keeps the counters bounded if the divider shrinks mid-frame
  assign tx_tick    = (tx_cnt_q >= div_q);
  assign rx_tick    = (rx_cnt_q >= div_q);
  assign rx_half    = (rx_cnt_q >= (div_q >> 1));

  assign tx_o       = tx_q;
  assign div_o      = div_q;
  assign dat_o      = rx_valid_q ? {24'd0, rx_data_q} : 32'hFFFF_FFFF;
  assign dat_wait_o = dat_we_i && tx_busy;
  assign irq_o      = rx_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_q <= DIV_RESET;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (div_we_i[i]) begin
          div_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // transmitter
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_state_q <= natv_periph_pkg::UART_IDLE;
      tx_cnt_q   <= '0;
      tx_idx_q   <= '0;
      tx_q       <= 1'b1;
    end else begin
      case (tx_state_q)
        natv_periph_pkg::UART_IDLE: begin
          if (dat_we_i) begin
            tx_q       <= 1'b0;
            tx_cnt_q   <= '0;
            tx_state_q <= natv_periph_pkg::UART_START;
          end
        end
        natv_periph_pkg::UART_START: begin
          if (tx_tick) begin
            tx_cnt_q   <= '0;
            tx_idx_q   <= '0;
            tx_q       <= tx_shift_q[0];
            tx_state_q <= natv_periph_pkg::UART_DATA;
          end else begin
            tx_cnt_q <= tx_cnt_q + 32'd1;
          end
        end
        natv_periph_pkg::UART_DATA: begin
          if (tx_tick) begin
            tx_cnt_q <= '0;
            tx_idx_q <= tx_idx_q + 3'd1;
            if (tx_idx_q == 3'd7) begin
              tx_q       <= 1'b1;
              tx_state_q <= natv_periph_pkg::UART_STOP;
            end else begin
              tx_q <= tx_shift_q[0];
            end
          end else begin
            tx_cnt_q <= tx_cnt_q + 32'd1;
          end
        end
        default: begin
          if (tx_tick) begin
            tx_cnt_q   <= '0;
            tx_state_q <= natv_periph_pkg::UART_IDLE;
          end else begin
            tx_cnt_q <= tx_cnt_q + 32'd1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!tx_busy && dat_we_i) begin
      tx_shift_q <= wdata_i[7:0];
    end else if (tx_tick && (tx_state_q == natv_periph_pkg::UART_START ||
                             tx_state_q == natv_periph_pkg::UART_DATA)) begin
      tx_shift_q <= {1'b0, tx_shift_q[7:1]};
    end
  end

  // receiver sampling at bit middles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_sync_q  <= 2'b11;
      rx_state_q <= natv_periph_pkg::UART_IDLE;
      rx_cnt_q   <= '0;
      rx_idx_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
      if (rx_state_q == natv_periph_pkg::UART_STOP && rx_tick) begin
        rx_valid_q <= 1'b1;
      end else if (dat_re_i) begin
        rx_valid_q <= 1'b0;
      end
      case (rx_state_q)
        natv_periph_pkg::UART_IDLE: begin
          rx_cnt_q <= '0;
          if (!rx_s) begin
            rx_state_q <= natv_periph_pkg::UART_START;
          end
        end
        natv_periph_pkg::UART_START: begin
          if (rx_half) begin
            rx_cnt_q <= '0;
            rx_idx_q <= '0;
            // a glitch shorter than half a bit is dropped
            rx_state_q <= rx_s ? natv_periph_pkg::UART_IDLE : natv_periph_pkg::UART_DATA;
          end else begin
            rx_cnt_q <= rx_cnt_q + 32'd1;
          end
        end
        natv_periph_pkg::UART_DATA: begin
          if (rx_tick) begin
            rx_cnt_q <= '0;
            rx_idx_q <= rx_idx_q + 3'd1;
            if (rx_idx_q == 3'd7) begin
              rx_state_q <= natv_periph_pkg::UART_STOP;
            end
          end else begin
            rx_cnt_q <= rx_cnt_q + 32'd1;
          end
        end
        default: begin
          if (rx_tick) begin
            rx_cnt_q   <= '0;
            rx_state_q <= natv_periph_pkg::UART_IDLE;
          end else begin
            rx_cnt_q <= rx_cnt_q + 32'd1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_state_q == natv_periph_pkg::UART_DATA && rx_tick) begin
      rx_shift_q <= {rx_s, rx_shift_q[7:1]};
    end
    if (rx_state_q == natv_periph_pkg::UART_STOP && rx_tick) begin
      rx_data_q <= rx_shift_q;
    end
  end

endmodule

`default_nettype wire

//--- hw/natv_timer.sv
// 32-bit countdown timer with optional periodic reload and a zero interrupt
`timescale 1ns/1ps
`default_nettype none

module natv_timer (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        cfg_we_i,
  input  wire logic [3:0]  val_we_i,
  input  wire logic [3:0]  dat_we_i,
  input  wire logic [31:0] wdata_i,
  output logic [31:0]      cfg_o,
  output logic [31:0]      val_o,
  output logic [31:0]      dat_o,
  output logic             irq_o
);

  logic [2:0]  cfg_q;
  logic [31:0] val_q;
  logic [31:0] dat_q;
  logic        cnt_en;
  logic        irq_en;
  logic        periodic;
  logic        at_zero;

  // bit 0 enable, bit 1 irq enable, bit 2 periodic
  assign cnt_en   = cfg_q[0];
  assign irq_en   = cfg_q[1];
  assign periodic = cfg_q[2];
  assign at_zero  = (val_q == 32'd0);

  assign cfg_o = {29'd0, cfg_q};
  assign val_o = val_q;
  assign dat_o = dat_q;
  assign irq_o = irq_en && at_zero;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      cfg_q <= wdata_i[2:0];
    end
  end

  // reload value
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dat_q <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (dat_we_i[i]) begin
          dat_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // a bus write wins over counting in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      val_q <= '0;
    end else if (|val_we_i) begin
      for (int i = 0; i < 4; i++) begin
        if (val_we_i[i]) begin
          val_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end else if (cnt_en) begin
      if (!at_zero) begin
        val_q <= val_q - 32'd1;
      end else if (periodic) begin
        val_q <= dat_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/ip_natv_wrapper.sv
// native bus peripheral wrapper: gpio, memory config, uart and two timers
`timescale 1ns/1ps
`default_nettype none

module ip_natv_wrapper #(
  parameter logic [31:0] UART_DIV_RESET = 32'd16
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_n_i,
  input  wire natv_periph_pkg::natv_req_t  natv_req_i,
  output natv_periph_pkg::natv_rsp_t       natv_rsp_o,
  output natv_periph_pkg::gpio_pad_t       gpio_pad_o,
  input  wire logic [7:0]                  gpio_in_i,
  input  wire logic                        uart_rx_i,
  output logic                             uart_tx_o,
  output logic                             psram_cfg_wait_wr_en_o,
  input  wire logic [4:0]                  psram_cfg_wait_i,
  output logic [4:0]                       psram_cfg_wait_o,
  output logic                             psram_cfg_chd_wr_en_o,
  input  wire logic [2:0]                  psram_cfg_chd_i,
  output logic [2:0]                       psram_cfg_chd_o,
  output logic [1:0]                       spisd_cfg_clkdiv_o,
  output logic [2:0]                       irq_o
);

  logic        ready_d;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        acc;
  logic        acc_wr;
  logic        acc_rd;
  logic [15:0] offs;
  logic [3:0]  wstrb;
  logic [31:0] wdata;

  logic [7:0]  gpio_out_q;
  logic [7:0]  gpio_oeb_q;
  logic [7:0]  gpio_pub_q;
  logic [7:0]  gpio_pdb_q;
  logic [4:0]  psram_wait_q;
  logic [2:0]  psram_chd_q;
  logic [1:0]  spisd_div_q;

  logic        sel_uart_div;
  logic        sel_uart_dat;
  logic        sel_tim0_cfg;
  logic        sel_tim0_val;
  logic        sel_tim0_dat;
  logic        sel_tim1_cfg;
  logic        sel_tim1_val;
  logic        sel_tim1_dat;
  logic        sel_psram_wait;
  logic        sel_psram_chd;

  logic [31:0] uart_div_rd;
  logic [31:0] uart_dat_rd;
  logic        uart_dat_wait;
  logic [31:0] tim0_cfg_rd;
  logic [31:0] tim0_val_rd;
  logic [31:0] tim0_dat_rd;
  logic [31:0] tim1_cfg_rd;
  logic [31:0] tim1_val_rd;
  logic [31:0] tim1_dat_rd;

  assign offs  = natv_req_i.addr[15:0];
  assign wstrb = natv_req_i.wstrb;
  assign wdata = natv_req_i.wdata;

  // an access is live until its ready cycle
  assign acc    = natv_req_i.valid && !ready_q;
  assign acc_wr = acc && (|wstrb);
  assign acc_rd = acc && !(|wstrb);

  assign sel_uart_div   = acc && (offs == natv_periph_pkg::REG_UART_DIV);
  assign sel_uart_dat   = acc && (offs == natv_periph_pkg::REG_UART_DAT);
  assign sel_tim0_cfg   = acc && (offs == natv_periph_pkg::REG_TIM0_CFG);
  assign sel_tim0_val   = acc && (offs == natv_periph_pkg::REG_TIM0_VAL);
  assign sel_tim0_dat   = acc && (offs == natv_periph_pkg::REG_TIM0_DAT);
  assign sel_tim1_cfg   = acc && (offs == natv_periph_pkg::REG_TIM1_CFG);
  assign sel_tim1_val   = acc && (offs == natv_periph_pkg::REG_TIM1_VAL);
  assign sel_tim1_dat   = acc && (offs == natv_periph_pkg::REG_TIM1_DAT);
  assign sel_psram_wait = acc && (offs == natv_periph_pkg::REG_PSRAM_WAIT);
  assign sel_psram_chd  = acc && (offs == natv_periph_pkg::REG_PSRAM_CHD);

  assign psram_cfg_wait_wr_en_o = sel_psram_wait && wstrb[0];
  assign psram_cfg_chd_wr_en_o  = sel_psram_chd && wstrb[0];
  assign psram_cfg_wait_o       = psram_wait_q;
  assign psram_cfg_chd_o        = psram_chd_q;
  assign spisd_cfg_clkdiv_o     = spisd_div_q;

  assign gpio_pad_o.out = gpio_out_q;
  // pads stay tristated through reset
  assign gpio_pad_o.oeb = {8{~rst_n_i}} | gpio_oeb_q;
  assign gpio_pad_o.pub = gpio_pub_q;
  assign gpio_pad_o.pdb = gpio_pdb_q;

  assign natv_rsp_o.rdata = rdata_q;
  assign natv_rsp_o.ready = ready_q;

  // uart data writes hold off while the transmitter is busy
  assign ready_d = acc && !(sel_uart_dat && uart_dat_wait);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= ready_d;
    end
  end

  // local registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_out_q   <= '0;
      gpio_oeb_q   <= '1;
      gpio_pub_q   <= '0;
      gpio_pdb_q   <= '0;
      psram_wait_q <= '0;
      psram_chd_q  <= '0;
      spisd_div_q  <= '0;
    end else if (acc_wr && wstrb[0]) begin
      case (offs)
        natv_periph_pkg::REG_GPIO_DATA:  gpio_out_q   <= wdata[7:0];
        natv_periph_pkg::REG_GPIO_OEB:   gpio_oeb_q   <= wdata[7:0];
        natv_periph_pkg::REG_GPIO_PUB:   gpio_pub_q   <= wdata[7:0];
        natv_periph_pkg::REG_GPIO_PDB:   gpio_pdb_q   <= wdata[7:0];
        natv_periph_pkg::REG_PSRAM_WAIT: psram_wait_q <= wdata[4:0];
        natv_periph_pkg::REG_PSRAM_CHD:  psram_chd_q  <= wdata[2:0];
        natv_periph_pkg::REG_SPISD_DIV:  spisd_div_q  <= wdata[1:0];
        default: ;
      endcase
    end
  end

  // read data captured before any write of the same access lands
  always_ff @(posedge clk_i) begin
    if (acc) begin
      case (offs)
        natv_periph_pkg::REG_GPIO_DATA:  rdata_q <= {16'd0, gpio_out_q, gpio_in_i};
        natv_periph_pkg::REG_GPIO_OEB:   rdata_q <= {24'd0, gpio_oeb_q};
        natv_periph_pkg::REG_GPIO_PUB:   rdata_q <= {24'd0, gpio_pub_q};
        natv_periph_pkg::REG_GPIO_PDB:   rdata_q <= {24'd0, gpio_pdb_q};
        natv_periph_pkg::REG_UART_DIV:   rdata_q <= uart_div_rd;
        natv_periph_pkg::REG_UART_DAT:   rdata_q <= uart_dat_rd;
        natv_periph_pkg::REG_TIM0_CFG:   rdata_q <= tim0_cfg_rd;
        natv_periph_pkg::REG_TIM0_VAL:   rdata_q <= tim0_val_rd;
        natv_periph_pkg::REG_TIM0_DAT:   rdata_q <= tim0_dat_rd;
        natv_periph_pkg::REG_TIM1_CFG:   rdata_q <= tim1_cfg_rd;
        natv_periph_pkg::REG_TIM1_VAL:   rdata_q <= tim1_val_rd;
        natv_periph_pkg::REG_TIM1_DAT:   rdata_q <= tim1_dat_rd;
        // live value from the psram controller
        natv_periph_pkg::REG_PSRAM_WAIT: rdata_q <= {27'd0, psram_cfg_wait_i};
        natv_periph_pkg::REG_PSRAM_CHD:  rdata_q <= {29'd0, psram_cfg_chd_i};
        natv_periph_pkg::REG_SPISD_DIV:  rdata_q <= {30'd0, spisd_div_q};
        default:                         rdata_q <= '0;
      endcase
    end
  end

  natv_uart #(
    .DIV_RESET (UART_DIV_RESET)
  ) i_uart (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rx_i       (uart_rx_i),
    .tx_o       (uart_tx_o),
    .div_we_i   (sel_uart_div ? wstrb : 4'b0000),
    .dat_we_i   (sel_uart_dat && wstrb[0]),
    .dat_re_i   (sel_uart_dat && acc_rd),
    .wdata_i    (wdata),
    .div_o      (uart_div_rd),
    .dat_o      (uart_dat_rd),
    .dat_wait_o (uart_dat_wait),
    .irq_o      (irq_o[0])
  );

  natv_timer i_tim0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cfg_we_i (sel_tim0_cfg && wstrb[0]),
    .val_we_i (sel_tim0_val ? wstrb : 4'b0000),
    .dat_we_i (sel_tim0_dat ? wstrb : 4'b0000),
    .wdata_i  (wdata),
    .cfg_o    (tim0_cfg_rd),
    .val_o    (tim0_val_rd),
    .dat_o    (tim0_dat_rd),
    .irq_o    (irq_o[1])
  );

  natv_timer i_tim1 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cfg_we_i (sel_tim1_cfg && wstrb[0]),
    .val_we_i (sel_tim1_val ? wstrb : 4'b0000),
    .dat_we_i (sel_tim1_dat ? wstrb : 4'b0000),
    .wdata_i  (wdata),
    .cfg_o    (tim1_cfg_rd),
    .val_o    (tim1_val_rd),
    .dat_o    (tim1_dat_rd),
    .irq_o    (irq_o[2])
  );

endmodule

`default_nettype wire

//--- testbench/tb_ip_natv.sv
// testbench for the native bus peripheral wrapper covering gpio, config, uart and timers
`timescale 1ns/1ps
`default_nettype none

module tb_ip_natv;

  localparam int          CLK_PERIOD      = 100;
  localparam logic [31:0] UART_DIV        = 32'd3;
  localparam int          BIT_CLKS        = int'(UART_DIV) + 1;
  localparam int          WATCHDOG_CYCLES = 200000;

  logic                       clk_i;
  logic                       rst_n_i;
  natv_periph_pkg::natv_req_t req;
  natv_periph_pkg::natv_rsp_t rsp;
  natv_periph_pkg::gpio_pad_t pad;
  logic [7:0]                 gpio_in;
  logic                       uart_rx;
  logic                       uart_tx;
  logic                       wait_wr_en;
  logic [4:0]                 wait_in;
  logic [4:0]                 wait_out;
  logic                       chd_wr_en;
  logic [2:0]                 chd_in;
  logic [2:0]                 chd_out;
  logic [1:0]                 spisd_div;
  logic [2:0]                 irq;
  int unsigned                cyc = 0;
  int unsigned                issue_cyc;
  // write enables seen in the request cycle and in the ready cycle
  logic [1:0]                 wr_en_req;
  logic [1:0]                 wr_en_rdy;
  logic                       first_frame_done;

  ip_natv_wrapper #(
    .UART_DIV_RESET (UART_DIV)
  ) i_dut (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .natv_req_i             (req),
    .natv_rsp_o             (rsp),
    .gpio_pad_o             (pad),
    .gpio_in_i              (gpio_in),
    .uart_rx_i              (uart_rx),
    .uart_tx_o              (uart_tx),
    .psram_cfg_wait_wr_en_o (wait_wr_en),
    .psram_cfg_wait_i       (wait_in),
    .psram_cfg_wait_o       (wait_out),
    .psram_cfg_chd_wr_en_o  (chd_wr_en),
    .psram_cfg_chd_i        (chd_in),
    .psram_cfg_chd_o        (chd_out),
    .spisd_cfg_clkdiv_o     (spisd_div),
    .irq_o                  (irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic report_error(input string why);
    $display("error at %0t: %s", $time, why);
    stop_with_failure();
  endtask

  task automatic check_rsp(input string name, input natv_periph_pkg::natv_rsp_t got,
                           input logic [31:0] exp);
    if (got.rdata !== exp) begin
      $display("FAIL time=%0t %s got=%08h exp=%08h", $time, name, got.rdata, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_pad(input natv_periph_pkg::gpio_pad_t got,
                           input natv_periph_pkg::gpio_pad_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t gpio_pad_o got=%08h exp=%08h", $time, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%b exp=%b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%08h exp=%08h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic require_single_cycle(input int lat, input string what);
    if (lat != 1) begin
      report_error($sformatf("%s got ready after %0d cycles instead of 1", what, lat));
    end
  endtask

  // one bus access driven on the falling edge and held until ready
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output natv_periph_pkg::natv_rsp_t r,
                            output int lat);
    lat = 0;
    @(negedge clk_i);
    req.valid = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    req.wstrb = strb;
    issue_cyc = cyc;
    #1;
    wr_en_req = {wait_wr_en, chd_wr_en};
    do begin
      @(negedge clk_i);
      lat++;
    end while (!rsp.ready);
    r         = rsp;
    wr_en_rdy = {wait_wr_en, chd_wr_en};
    req       = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output int lat);
    natv_periph_pkg::natv_rsp_t unused_rsp;
    bus_access(addr, data, strb, unused_rsp, lat);
  endtask

  task automatic bus_read(input logic [31:0] addr, output natv_periph_pkg::natv_rsp_t r,
                          output int lat);
    bus_access(addr, 32'd0, 4'b0000, r, lat);
  endtask

  // m[0] out, m[1] oeb, m[2] pub, m[3] pdb
  function automatic logic [31:0] gpio_readback(input int idx, input logic [3:0][7:0] m,
                                                input logic [7:0] gin);
    if (idx == 0) return {16'd0, m[0], gin};
    return {24'd0, m[idx]};
  endfunction

  function automatic natv_periph_pkg::gpio_pad_t gpio_pad_ref(input logic [3:0][7:0] m);
    natv_periph_pkg::gpio_pad_t p;
    p.out = m[0];
    p.oeb = m[1];
    p.pub = m[2];
    p.pdb = m[3];
    return p;
  endfunction

  // start bit, eight data bits lsb first, stop bit
  function automatic logic uart_frame_bit(input logic [7:0] data, input int idx);
    if (idx == 0) return 1'b0;
    if (idx == 9) return 1'b1;
    return data[idx - 1];
  endfunction

  function automatic logic [31:0] timer_value(input logic [31:0] start, input int unsigned k,
                                              input logic periodic, input logic [31:0] reload);
    int unsigned past;
    if (k <= start) return start - k;
    if (!periodic) return 32'd0;
    // one clock at zero and then a reload period of reload+1
    past = k - start - 1;
    return reload - (past % (reload + 1));
  endfunction

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  initial begin : main
    natv_periph_pkg::natv_rsp_t r;
    logic [3:0][7:0] gpio_model;
    int              lat;
    int              lat2;
    int              idx;
    logic [31:0]     val;
    logic [31:0]     n;
    logic [31:0]     reload;
    logic [31:0]     prev;
    logic [7:0]      tx_byte [2];
    logic [7:0]      rx_byte;
    int unsigned     cfg_cyc;
    logic            reloaded;

    void'($urandom(32'hceab_4568));
    req              = '0;
    gpio_in          = '0;
    uart_rx          = 1'b1;
    wait_in          = '0;
    chd_in           = '0;
    rst_n_i          = 1'b0;
    wr_en_req        = '0;
    wr_en_rdy        = '0;
    first_frame_done = 1'b0;
    gpio_model       = '0;
    gpio_model[1]    = 8'hFF;

    // pads must stay tristated throughout reset
    repeat (8) @(negedge clk_i);
    check_pad(pad, gpio_pad_ref(gpio_model));
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_pad(pad, gpio_pad_ref(gpio_model));
    for (int b = 0; b < 3; b++) begin
      check_bit($sformatf("irq_o[%0d]", b), irq[b], 1'b0);
    end
    check_bit("natv_rsp_o.ready", rsp.ready, 1'b0);
    check_bit("uart_tx_o", uart_tx, 1'b1);
    check_bit("psram_cfg_wait_wr_en_o", wait_wr_en, 1'b0);
    check_bit("psram_cfg_chd_wr_en_o", chd_wr_en, 1'b0);

    // gpio
    for (int i = 0; i < 20; i++) begin
      idx = int'($urandom_range(3, 0));
      val = $urandom;
      bus_write(idx * 4, val, 4'hF, lat);
      require_single_cycle(lat, "gpio write");
      gpio_model[idx] = val[7:0];
      check_pad(pad, gpio_pad_ref(gpio_model));
      gpio_in = 8'($urandom);
      bus_read(idx * 4, r, lat);
      require_single_cycle(lat, "gpio read");
      check_rsp($sformatf("gpio reg %0d rdata", idx), r, gpio_readback(idx, gpio_model, gpio_in));
      bus_read(32'h0000_0000, r, lat);
      require_single_cycle(lat, "gpio data read");
      check_rsp("gpio data rdata", r, gpio_readback(0, gpio_model, gpio_in));
    end

    // memory configuration
    val     = $urandom;
    wait_in = ~val[4:0];
    bus_write(32'h0000_4000, val, 4'hF, lat);
    require_single_cycle(lat, "psram wait write");
    check_bit("psram_cfg_wait_wr_en_o in request", wr_en_req[1], 1'b1);
    check_bit("psram_cfg_chd_wr_en_o in request", wr_en_req[0], 1'b0);
    check_bit("psram_cfg_wait_wr_en_o at ready", wr_en_rdy[1], 1'b0);
    check_word("psram_cfg_wait_o", {27'd0, wait_out}, {27'd0, val[4:0]});
    bus_read(32'h0000_4000, r, lat);
    check_rsp("psram wait rdata", r, {27'd0, wait_in});
    val    = $urandom;
    chd_in = ~val[2:0];
    bus_write(32'h0000_4004, val, 4'hF, lat);
    check_bit("psram_cfg_chd_wr_en_o in request", wr_en_req[0], 1'b1);
    check_bit("psram_cfg_wait_wr_en_o in request", wr_en_req[1], 1'b0);
    check_bit("psram_cfg_chd_wr_en_o at ready", wr_en_rdy[0], 1'b0);
    check_word("psram_cfg_chd_o", {29'd0, chd_out}, {29'd0, val[2:0]});
    bus_read(32'h0000_4004, r, lat);
    check_rsp("psram chd rdata", r, {29'd0, chd_in});
    val = $urandom;
    bus_write(32'h0000_5000, val, 4'hF, lat);
    check_word("spisd_cfg_clkdiv_o", {30'd0, spisd_div}, {30'd0, val[1:0]});
    bus_read(32'h0000_5000, r, lat);
    check_rsp("spisd div rdata", r, {30'd0, val[1:0]});

    // uart transmit with a second write landing mid frame
    val = $urandom;
    bus_write(32'h0000_1000, val, 4'hF, lat);
    bus_read(32'h0000_1000, r, lat);
    check_rsp("uart div rdata", r, val);
    bus_write(32'h0000_1000, UART_DIV, 4'hF, lat);
    bus_read(32'h0000_1000, r, lat);
    check_rsp("uart div rdata", r, UART_DIV);
    tx_byte[0] = 8'($urandom);
    tx_byte[1] = 8'($urandom);
    fork
      begin
        for (int f = 0; f < 2; f++) begin
          @(negedge uart_tx);
          repeat (BIT_CLKS / 2 + 1) @(negedge clk_i);
          for (int b = 0; b < 10; b++) begin
            if (b > 0) repeat (BIT_CLKS) @(negedge clk_i);
            check_bit($sformatf("uart_tx_o frame %0d bit %0d", f, b), uart_tx,
                      uart_frame_bit(tx_byte[f], b));
          end
          first_frame_done = 1'b1;
        end
      end
      begin
        bus_write(32'h0000_1004, {24'd0, tx_byte[0]}, 4'b0001, lat);
        repeat (10) @(negedge clk_i);
        bus_write(32'h0000_1004, {24'd0, tx_byte[1]}, 4'b0001, lat2);
        if (!first_frame_done || lat2 <= 1) begin
          report_error("second uart write got ready before the first frame ended");
        end
      end
    join

    // uart receive
    rx_byte = 8'($urandom);
    for (int b = 0; b < 10; b++) begin
      @(negedge clk_i);
      uart_rx = uart_frame_bit(rx_byte, b);
      repeat (BIT_CLKS - 1) @(negedge clk_i);
    end
    lat = 0;
    while (!irq[0]) begin
      @(negedge clk_i);
      lat++;
      if (lat > 4 * BIT_CLKS) begin
        report_error("uart receive interrupt did not rise after the stop bit");
      end
    end
    bus_read(32'h0000_1004, r, lat);
    check_rsp("uart data rdata", r, {24'd0, rx_byte});
    check_bit("irq_o[0] after read", irq[0], 1'b0);
    bus_read(32'h0000_1004, r, lat);
    check_rsp("uart empty rdata", r, 32'hFFFF_FFFF);

    // timer 0 as a one shot with interrupt
    n = $urandom_range(60, 20);
    bus_write(32'h0000_2004, n, 4'hF, lat);
    bus_write(32'h0000_2000, 32'h0000_0003, 4'b0001, lat);
    cfg_cyc = issue_cyc;
    bus_read(32'h0000_2004, r, lat);
    check_rsp("tim0 value rdata", r, timer_value(n, issue_cyc - cfg_cyc - 1, 1'b0, 32'd0));
    for (int i = 0; i < n + 8; i++) begin
      @(negedge clk_i);
      check_bit("irq_o[1]", irq[1],
                timer_value(n, cyc - cfg_cyc - 1, 1'b0, 32'd0) == 32'd0);
    end

    // timer 1 with periodic reload
    reload = $urandom_range(12, 6);
    n      = $urandom_range(8, 4);
    bus_write(32'h0000_3008, reload, 4'hF, lat);
    bus_read(32'h0000_3008, r, lat);
    check_rsp("tim1 reload rdata", r, reload);
    bus_write(32'h0000_3004, n, 4'hF, lat);
    bus_write(32'h0000_3000, 32'h0000_0005, 4'b0001, lat);
    cfg_cyc  = issue_cyc;
    prev     = n;
    reloaded = 1'b0;
    for (int i = 0; i < 12; i++) begin
      bus_read(32'h0000_3004, r, lat);
      check_rsp($sformatf("tim1 value read %0d", i), r,
                timer_value(n, issue_cyc - cfg_cyc - 1, 1'b1, reload));
      if (r.rdata > prev) reloaded = 1'b1;
      prev = r.rdata;
    end
    if (!reloaded) begin
      report_error("timer 1 never reloaded in periodic mode");
    end
    // one full reload period passes through zero with the interrupt disabled
    for (int i = 0; i <= reload; i++) begin
      @(negedge clk_i);
      check_bit("irq_o[2]", irq[2], 1'b0);
    end

    // unmapped offset
    bus_read(32'h0000_6000, r, lat);
    require_single_cycle(lat, "unmapped read");
    check_rsp("unmapped rdata", r, 32'd0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hw/natv_periph_pkg.sv
hw/natv_uart.sv
hw/natv_timer.sv
hw/ip_natv_wrapper.sv
testbench/tb_ip_natv.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and decides pass or fail from the log

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
TOP=tb_ip_natv

rm -rf "$OBJ_DIR"

verilator --binary -j 0 --top-module "$TOP" -f files.f -Mdir "$OBJ_DIR" -o "$TOP" \
  > "$BUILD_LOG" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "pass message not found in $SIM_LOG"
exit 1
